//--- all.f
+incdir+.
alu_pkg.sv
alu_core.sv
alu_cmd_fifo.sv
alu_issue.sv
alu_exec.sv
alu_unit_top.sv
tb_alu_unit.sv

//--- alu_cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_params.svh"

module alu_cmd_fifo (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire                      i_push,
    input  wire alu_pkg::alu_op_e    i_push_op,
    input  wire [`ALU_DATA_W-1:0]    i_push_a,
    input  wire [`ALU_DATA_W-1:0]    i_push_b,
    input  wire                      i_pop,
    output logic                     o_full,
    output logic                     o_empty,
    output alu_pkg::alu_op_e         o_head_op,
    output logic [`ALU_DATA_W-1:0]   o_head_a,
    output logic [`ALU_DATA_W-1:0]   o_head_b
);

    localparam logic [`ALU_FIFO_AW:0] FULL_CNT = `ALU_FIFO_DEPTH;

    alu_pkg::alu_op_e       mem_op [`ALU_FIFO_DEPTH];
    logic [`ALU_DATA_W-1:0] mem_a  [`ALU_FIFO_DEPTH];
    logic [`ALU_DATA_W-1:0] mem_b  [`ALU_FIFO_DEPTH];

    logic [`ALU_FIFO_AW-1:0] wr_ptr;
    logic [`ALU_FIFO_AW-1:0] rd_ptr;
    logic [`ALU_FIFO_AW:0]   count;   // Occupancy, one bit wider than pointers

    assign o_full    = (count == FULL_CNT);
    assign o_empty   = (count == '0);
    assign o_head_op = mem_op[rd_ptr];
    assign o_head_a  = mem_a[rd_ptr];
    assign o_head_b  = mem_b[rd_ptr];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem_op[wr_ptr] <= i_push_op;
            mem_a[wr_ptr]  <= i_push_a;
            mem_b[wr_ptr]  <= i_push_b;
        end
    end

endmodule

`default_nettype wire

//--- alu_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_params.svh"

module alu_core (
    input  wire alu_pkg::alu_op_e    i_op_code,
    input  wire [`ALU_DATA_W-1:0]    i_op_a,
    input  wire [`ALU_DATA_W-1:0]    i_op_b,
    output logic [`ALU_DATA_W-1:0]   o_rslt,
    output logic                     o_zero,
    output logic                     o_carry,
    output logic                     o_ovfl_exception
);

    localparam int W = `ALU_DATA_W;

    logic [W:0]   a_zx;      // Zero-extended operands
    logic [W:0]   b_zx;
    logic [W:0]   a_sx;      // Sign-extended operands
    logic [W:0]   b_sx;
    logic [4:0]   shamt;
    logic         gt_flag;
    logic         eq_flag;
    logic [W:0]   result;
    logic         overflow;

    assign a_zx    = {1'b0, i_op_a};
    assign b_zx    = {1'b0, i_op_b};
    assign a_sx    = {i_op_a[W-1], i_op_a};
    assign b_sx    = {i_op_b[W-1], i_op_b};
    assign shamt   = i_op_b[4:0];
    assign gt_flag = $signed(i_op_a) > $signed(i_op_b);
    assign eq_flag = (i_op_a == i_op_b);

    always_comb begin
        result   = '0;
        overflow = 1'b0;  // Only ADD can raise it
        case (i_op_code)
            alu_pkg::OP_LSR:  result = a_zx >> shamt;
            alu_pkg::OP_LSL:  result = a_zx << shamt;   // Bit shifted out lands in carry
            alu_pkg::OP_ASR:  result = $signed(a_sx) >>> shamt;
            alu_pkg::OP_UADD: result = a_zx + b_zx;
            alu_pkg::OP_USUB: result = b_zx - a_zx;     // Reversed order, borrow in carry
            alu_pkg::OP_AND:  result = a_zx & b_zx;
            alu_pkg::OP_OR:   result = a_zx | b_zx;
            alu_pkg::OP_XOR:  result = a_zx ^ b_zx;
            alu_pkg::OP_NOR:  result = {1'b0, ~(i_op_a | i_op_b)};
            alu_pkg::OP_GT:   result = {{W{1'b0}}, gt_flag};
            alu_pkg::OP_CMP:  result = {{W{1'b0}}, eq_flag};
            alu_pkg::OP_ADD: begin
                result = a_sx + b_sx;
                // Same operand signs but result sign flipped
                overflow = (i_op_a[W-1] == i_op_b[W-1]) && (result[W-1] != i_op_a[W-1]);
            end
            default: begin
                result   = '0;    // Undefined opcode
                overflow = 1'b0;
            end
        endcase
    end

    assign o_rslt           = result[W-1:0];
    assign o_carry          = result[W];
    assign o_zero           = ~|result;      // All 33 bits
    assign o_ovfl_exception = overflow;

endmodule

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_params.svh"

module alu_exec (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire                      i_hold,
    input  wire                      i_empty,
    input  wire alu_pkg::alu_op_e    i_head_op,
    input  wire [`ALU_DATA_W-1:0]    i_head_a,
    input  wire [`ALU_DATA_W-1:0]    i_head_b,
    output logic                     o_pop,
    output logic                     o_rslt_valid,
    output logic [`ALU_DATA_W-1:0]   o_rslt,
    output logic                     o_zero,
    output logic                     o_carry,
    output logic                     o_ovfl
);

    logic [`ALU_DATA_W-1:0] core_rslt;
    logic                   core_zero;
    logic                   core_carry;
    logic                   core_ovfl;

    assign o_pop = !i_empty && !i_hold;  // One command per cycle unless held

    alu_core alu_core_inst (
        .i_op_code        (i_head_op),
        .i_op_a           (i_head_a),
        .i_op_b           (i_head_b),
        .o_rslt           (core_rslt),
        .o_zero           (core_zero),
        .o_carry          (core_carry),
        .o_ovfl_exception (core_ovfl)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rslt_valid <= 1'b0;
            o_rslt       <= '0;
            o_zero       <= 1'b0;
            o_carry      <= 1'b0;
            o_ovfl       <= 1'b0;
        end else begin
            o_rslt_valid <= o_pop;       // Single-cycle strobe per popped command
            if (o_pop) begin
                o_rslt  <= core_rslt;
                o_zero  <= core_zero;
                o_carry <= core_carry;
                o_ovfl  <= core_ovfl;
            end
        end
    end

endmodule

`default_nettype wire

//--- alu_issue.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_params.svh"

module alu_issue (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire                      i_wr_en,
    input  wire [`ALU_REG_AW-1:0]    i_wr_addr,
    input  wire [`ALU_DATA_W-1:0]    i_wr_data,
    input  wire                      i_issue,
    input  wire alu_pkg::alu_op_e    i_op,
    input  wire [`ALU_REG_AW-1:0]    i_src_a,
    input  wire [`ALU_REG_AW-1:0]    i_src_b,
    input  wire                      i_full,
    output logic                     o_push,
    output alu_pkg::alu_op_e         o_push_op,
    output logic [`ALU_DATA_W-1:0]   o_push_a,
    output logic [`ALU_DATA_W-1:0]   o_push_b,
    output logic                     o_cmd_drop
);

    logic [`ALU_DATA_W-1:0] regs [`ALU_NUM_REGS];  // Operand register file

    logic pend_valid;   // Issue register holds a command
    logic pend_stuck;   // Held command cannot leave this cycle
    logic take_issue;   // New command enters the issue register

    // A held command blocks a new issue only while the FIFO is full
    assign pend_stuck = pend_valid && i_full;
    assign take_issue = i_issue && !pend_stuck;
    assign o_push     = pend_valid && !i_full;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `ALU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;  // Issue in the same cycle reads old value
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend_valid <= 1'b0;
            o_cmd_drop <= 1'b0;
        end else begin
            o_cmd_drop <= i_issue && pend_stuck;  // Newest command is discarded
            if (take_issue) begin
                pend_valid <= 1'b1;
            end else if (o_push) begin
                pend_valid <= 1'b0;
            end
        end
    end

    // Command payload
    always_ff @(posedge i_clk) begin
        if (take_issue) begin
            o_push_op <= i_op;
            o_push_a  <= regs[i_src_a];
            o_push_b  <= regs[i_src_b];
        end
    end

endmodule

`default_nettype wire

//--- alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Datapath
`define ALU_DATA_W      32  // Operand and result width

// Operand register file
`define ALU_NUM_REGS    8   // Number of operand registers
`define ALU_REG_AW      3   // Register index width

// Command FIFO
`define ALU_FIFO_DEPTH  4   // Entries
`define ALU_FIFO_AW     2   // Pointer width

`endif

//--- alu_pkg.sv
`default_nettype none

package alu_pkg;

    // ALU opcodes, encodings as used by the control unit
    // Codes 3, 13, 14 and 15 are undefined and give a zero result
    typedef enum logic [3:0] {
        OP_LSR  = 4'd0,   // Logical shift right
        OP_LSL  = 4'd1,   // Logical shift left
        OP_ASR  = 4'd2,   // Arithmetic shift right
        OP_UADD = 4'd4,   // Unsigned add
        OP_USUB = 4'd5,   // Unsigned sub, B minus A
        OP_AND  = 4'd6,
        OP_OR   = 4'd7,
        OP_XOR  = 4'd8,
        OP_NOR  = 4'd9,
        OP_GT   = 4'd10,  // Signed greater than
        OP_CMP  = 4'd11,  // Equality
        OP_ADD  = 4'd12   // Signed add with overflow
    } alu_op_e;

endpackage

`default_nettype wire

//--- alu_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_params.svh"

module alu_unit_top (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire                      i_wr_en,
    input  wire [`ALU_REG_AW-1:0]    i_wr_addr,
    input  wire [`ALU_DATA_W-1:0]    i_wr_data,
    input  wire                      i_issue,
    input  wire alu_pkg::alu_op_e    i_op,
    input  wire [`ALU_REG_AW-1:0]    i_src_a,
    input  wire [`ALU_REG_AW-1:0]    i_src_b,
    input  wire                      i_hold,
    output logic                     o_cmd_drop,
    output logic                     o_rslt_valid,
    output logic [`ALU_DATA_W-1:0]   o_rslt,
    output logic                     o_zero,
    output logic                     o_carry,
    output logic                     o_ovfl
);

    // Issue to FIFO
    logic                   push;
    alu_pkg::alu_op_e       push_op;
    logic [`ALU_DATA_W-1:0] push_a;
    logic [`ALU_DATA_W-1:0] push_b;
    logic                   full;

    // FIFO to execute
    logic                   pop;
    logic                   empty;
    alu_pkg::alu_op_e       head_op;
    logic [`ALU_DATA_W-1:0] head_a;
    logic [`ALU_DATA_W-1:0] head_b;

    alu_issue alu_issue_inst (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_wr_en    (i_wr_en),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .i_issue    (i_issue),
        .i_op       (i_op),
        .i_src_a    (i_src_a),
        .i_src_b    (i_src_b),
        .i_full     (full),
        .o_push     (push),
        .o_push_op  (push_op),
        .o_push_a   (push_a),
        .o_push_b   (push_b),
        .o_cmd_drop (o_cmd_drop)
    );

    alu_cmd_fifo alu_cmd_fifo_inst (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_push     (push),
        .i_push_op  (push_op),
        .i_push_a   (push_a),
        .i_push_b   (push_b),
        .i_pop      (pop),
        .o_full     (full),
        .o_empty    (empty),
        .o_head_op  (head_op),
        .o_head_a   (head_a),
        .o_head_b   (head_b)
    );

    alu_exec alu_exec_inst (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_hold       (i_hold),
        .i_empty      (empty),
        .i_head_op    (head_op),
        .i_head_a     (head_a),
        .i_head_b     (head_b),
        .o_pop        (pop),
        .o_rslt_valid (o_rslt_valid),
        .o_rslt       (o_rslt),
        .o_zero       (o_zero),
        .o_carry      (o_carry),
        .o_ovfl       (o_ovfl)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f all.f --top-module tb_alu_unit \
    -Mdir obj_dir -o tb_alu_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_alu_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_params.svh"

module tb_alu_unit;

    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [3:0] OP_LIST [12] = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6,
                                             4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12};

    logic                    i_clk = 1'b0;
    logic                    i_arst_n;
    logic                    i_wr_en;
    logic [`ALU_REG_AW-1:0]  i_wr_addr;
    logic [`ALU_DATA_W-1:0]  i_wr_data;
    logic                    i_issue;
    alu_pkg::alu_op_e        i_op;
    logic [`ALU_REG_AW-1:0]  i_src_a;
    logic [`ALU_REG_AW-1:0]  i_src_b;
    logic                    i_hold;
    logic                    o_cmd_drop;
    logic                    o_rslt_valid;
    logic [`ALU_DATA_W-1:0]  o_rslt;
    logic                    o_zero;
    logic                    o_carry;
    logic                    o_ovfl;

    logic [`ALU_DATA_W-1:0]  shadow [`ALU_NUM_REGS];   // Mirror of the operand registers
    logic [`ALU_DATA_W+2:0]  exp_q [$];                // {ovfl, carry, zero, rslt}
    string                   name_q [$];
    logic [`ALU_DATA_W-1:0]  exp_rslt = '0;
    logic                    exp_zero = 1'b0;
    logic                    exp_carry = 1'b0;
    logic                    exp_ovfl = 1'b0;
    logic                    exp_present = 1'b0;
    string                   exp_name = "none";
    logic                    quiet_window = 1'b1;
    logic                    drop_allowed = 1'b0;
    logic                    aborted = 1'b0;
    logic [31:0]             rng;
    int                      mismatch_cnt = 0;
    int                      fail_cnt = 0;
    int                      drop_cnt = 0;
    int                      result_cnt = 0;

    alu_unit_top alu_unit_top_inst (.*);

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Reference ALU on a 64-bit scratch whose bits 32:0 form the wide result
    function automatic logic [`ALU_DATA_W+2:0] ref_alu(input logic [3:0] op,
                                                       input logic [31:0] a,
                                                       input logic [31:0] b);
        logic [63:0] t;
        logic        v;
        t = '0;
        v = 1'b0;
        case (op)
            4'd0:  t = {32'b0, a} >> b[4:0];
            4'd1:  t = {32'b0, a} << b[4:0];
            4'd2:  t = {{32{a[31]}}, a} >> b[4:0];   // Sign copies shift down
            4'd4:  t = {32'b0, a} + {32'b0, b};
            4'd5:  t = {32'b0, b} - {32'b0, a};      // Borrow wraps into bit 32
            4'd6:  t = {32'b0, a & b};
            4'd7:  t = {32'b0, a | b};
            4'd8:  t = {32'b0, a ^ b};
            4'd9:  t = {32'b0, ~(a | b)};
            4'd10: t = {63'b0, $signed(a) > $signed(b)};
            4'd11: t = {63'b0, a == b};
            4'd12: begin
                t = {{32{a[31]}}, a} + {{32{b[31]}}, b};
                v = (t[32] != t[31]);   // Sum outside the signed 32-bit range
            end
            default: t = '0;
        endcase
        return {v, t[32], t[32:0] == 33'b0, t[31:0]};
    endfunction

    // One stimulus cycle where the issue sees register contents from before the write
    task automatic drive_cycle(input logic wr, input logic [2:0] wa, input logic [31:0] wd,
                               input logic iss, input logic [3:0] op, input logic [2:0] sa,
                               input logic [2:0] sb, input string name, input logic dropped);
        i_wr_en   = wr;
        i_wr_addr = wa;
        i_wr_data = wd;
        i_issue   = iss;
        i_op      = alu_pkg::alu_op_e'(op);
        i_src_a   = sa;
        i_src_b   = sb;
        if (iss && !dropped) begin
            exp_q.push_back(ref_alu(op, shadow[sa], shadow[sb]));
            name_q.push_back(name);
        end
        if (wr) shadow[wa] = wd;
        @(negedge i_clk);
        i_wr_en = 1'b0;
        i_issue = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] wa, input logic [31:0] wd);
        drive_cycle(1'b1, wa, wd, 1'b0, 4'd0, 3'd0, 3'd0, "", 1'b0);
    endtask

    task automatic issue_op(input logic [3:0] op, input logic [2:0] sa, input logic [2:0] sb,
                            input string name, input logic dropped);
        drive_cycle(1'b0, 3'd0, '0, 1'b1, op, sa, sb, name, dropped);
    endtask

    task automatic check_op(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                            input string name);
        write_reg(3'd1, a);
        write_reg(3'd2, b);
        issue_op(op, 3'd1, 3'd2, name, 1'b0);
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < TIMEOUT_CYCLES && exp_q.size() != 0; n++) begin
            @(negedge i_clk);
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected results never came out", exp_q.size());
            fail_cnt++;
            aborted = 1'b1;
        end
        repeat (2) @(negedge i_clk);   // Last result still needs its check edge
    endtask

    task automatic run_directed();
        check_op(alu_pkg::OP_LSR,  32'h8000_0001, 32'd0,         "lsr_sh0");
        check_op(alu_pkg::OP_LSR,  32'h8000_0001, 32'd31,        "lsr_sh31");
        check_op(alu_pkg::OP_LSL,  32'hC000_0003, 32'd0,         "lsl_sh0");
        check_op(alu_pkg::OP_LSL,  32'hC000_0003, 32'd31,        "lsl_sh31");
        check_op(alu_pkg::OP_ASR,  32'h8000_0000, 32'd31,        "asr_neg_sh31");
        check_op(alu_pkg::OP_ASR,  32'hF000_00F0, 32'd4,         "asr_neg_sh4");
        check_op(alu_pkg::OP_ASR,  32'h7000_0000, 32'd0,         "asr_pos_sh0");
        check_op(alu_pkg::OP_UADD, 32'hFFFF_FFFF, 32'd1,         "uadd_wrap");
        check_op(alu_pkg::OP_UADD, 32'h7FFF_FFFF, 32'd1,         "uadd_no_ovfl");
        check_op(alu_pkg::OP_USUB, 32'd10,        32'd3,         "usub_a_gt_b");
        check_op(alu_pkg::OP_USUB, 32'd3,         32'd10,        "usub_a_lt_b");
        check_op(alu_pkg::OP_AND,  32'hF0F0_1234, 32'h0FF0_FF00, "and");
        check_op(alu_pkg::OP_OR,   32'hF0F0_1234, 32'h0FF0_FF00, "or");
        check_op(alu_pkg::OP_XOR,  32'hDEAD_BEEF, 32'hDEAD_BEEF, "xor_equal");
        check_op(alu_pkg::OP_XOR,  32'hDEAD_BEEF, 32'h1234_5678, "xor_diff");
        check_op(alu_pkg::OP_NOR,  32'hF0F0_0000, 32'h0000_000F, "nor");
        check_op(alu_pkg::OP_GT,   32'hFFFF_FFFE, 32'hFFFF_FFFB, "gt_neg_true");
        check_op(alu_pkg::OP_GT,   32'hFFFF_FFFB, 32'hFFFF_FFFE, "gt_neg_false");
        check_op(alu_pkg::OP_GT,   32'd1,         32'hFFFF_FFFF, "gt_pos_neg");
        check_op(alu_pkg::OP_CMP,  32'h1234_5678, 32'h1234_5678, "cmp_equal");
        check_op(alu_pkg::OP_CMP,  32'h1234_5678, 32'h1234_5679, "cmp_diff");
        check_op(alu_pkg::OP_ADD,  32'h7FFF_FFFF, 32'd1,         "add_pos_ovfl");
        check_op(alu_pkg::OP_ADD,  32'h8000_0000, 32'hFFFF_FFFF, "add_neg_ovfl");
        check_op(alu_pkg::OP_ADD,  32'hFFFF_FFFF, 32'd1,         "add_to_zero");
        check_op(4'd3,  32'hFFFF_FFFF, 32'hFFFF_FFFF, "undef_3");
        check_op(4'd13, 32'h1234_5678, 32'd7,         "undef_13");
        check_op(4'd14, 32'h8000_0000, 32'h8000_0000, "undef_14");
        check_op(4'd15, 32'hFFFF_FFFF, 32'd1,         "undef_15");
        wait_drain();
    endtask

    task automatic run_same_cycle();
        write_reg(3'd3, 32'h1111_1111);
        write_reg(3'd4, 32'h0000_0005);
        drive_cycle(1'b1, 3'd3, 32'h2222_2222, 1'b1, alu_pkg::OP_UADD, 3'd3, 3'd4,
                    "same_cycle_old", 1'b0);
        issue_op(alu_pkg::OP_UADD, 3'd3, 3'd4, "same_cycle_new", 1'b0);
        wait_drain();
    endtask

    task automatic run_hold_overflow();
        write_reg(3'd5, 32'h0000_0100);
        write_reg(3'd6, 32'h0000_0003);
        write_reg(3'd7, 32'hFFFF_FF00);
        drop_allowed = 1'b1;
        i_hold = 1'b1;   // Nothing pops so commands pile up
        issue_op(alu_pkg::OP_UADD, 3'd5, 3'd6, "hold_uadd", 1'b0);
        issue_op(alu_pkg::OP_USUB, 3'd6, 3'd5, "hold_usub", 1'b0);
        issue_op(alu_pkg::OP_LSL,  3'd6, 3'd6, "hold_lsl", 1'b0);
        issue_op(alu_pkg::OP_ADD,  3'd7, 3'd5, "hold_add", 1'b0);
        issue_op(alu_pkg::OP_XOR,  3'd5, 3'd7, "hold_xor", 1'b0);   // Waits in issue register
        issue_op(alu_pkg::OP_OR,   3'd5, 3'd6, "hold_dropped", 1'b1);
        repeat (3) @(negedge i_clk);
        i_hold = 1'b0;
        wait_drain();
        drop_allowed = 1'b0;
    endtask

    task automatic run_random(input int count);
        int          k;
        int          idx;
        logic [31:0] data;
        logic [31:0] sel;
        for (k = 0; k < `ALU_NUM_REGS; k++) begin
            rng = xorshift(rng);
            write_reg(3'(k), rng);
        end
        for (k = 0; k < count; k++) begin
            rng  = xorshift(rng);
            data = rng;
            rng  = xorshift(rng);
            sel  = rng;
            idx  = int'(sel[31:16]) % 12;
            drive_cycle(sel[9], sel[2:0], data, 1'b1, OP_LIST[idx], sel[5:3], sel[8:6],
                        "random", 1'b0);
        end
        wait_drain();
    endtask

    // Scoreboard head moves at the falling edge and is checked at the next rising edge
    always @(negedge i_clk) begin
        if (o_cmd_drop) drop_cnt++;
        if (o_rslt_valid) begin
            result_cnt++;
            exp_present = (exp_q.size() != 0);
            if (exp_present) begin
                {exp_ovfl, exp_carry, exp_zero, exp_rslt} = exp_q.pop_front();
                exp_name = name_q.pop_front();
            end
        end
    end

    a_quiet: assert property (@(posedge i_clk) !quiet_window || (!o_rslt_valid && !o_cmd_drop))
        else begin
            fail_cnt++;
            $display("Result valid or command drop active during or just after reset");
        end
    a_expected: assert property (@(posedge i_clk) !o_rslt_valid || exp_present)
        else begin
            fail_cnt++;
            $display("Result came out while no command was outstanding");
        end
    a_drop: assert property (@(posedge i_clk) !o_cmd_drop || drop_allowed)
        else begin
            fail_cnt++;
            $display("Command dropped although the FIFO should have had room");
        end
    a_rslt: assert property (@(posedge i_clk) !o_rslt_valid || !exp_present || o_rslt == exp_rslt)
        else begin
            mismatch_cnt++;
            $display("MISMATCH %s rslt expected %h actual %h", exp_name, exp_rslt,
                     $sampled(o_rslt));
        end
    a_zero: assert property (@(posedge i_clk) !o_rslt_valid || !exp_present || o_zero == exp_zero)
        else begin
            mismatch_cnt++;
            $display("MISMATCH %s zero expected %b actual %b", exp_name, exp_zero,
                     $sampled(o_zero));
        end
    a_carry: assert property (@(posedge i_clk)
                              !o_rslt_valid || !exp_present || o_carry == exp_carry)
        else begin
            mismatch_cnt++;
            $display("MISMATCH %s carry expected %b actual %b", exp_name, exp_carry,
                     $sampled(o_carry));
        end
    a_ovfl: assert property (@(posedge i_clk) !o_rslt_valid || !exp_present || o_ovfl == exp_ovfl)
        else begin
            mismatch_cnt++;
            $display("MISMATCH %s ovfl expected %b actual %b", exp_name, exp_ovfl,
                     $sampled(o_ovfl));
        end

    initial begin
        rng       = 32'd73835;
        i_arst_n  = 1'b0;
        i_wr_en   = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_issue   = 1'b0;
        i_op      = alu_pkg::OP_LSR;
        i_src_a   = '0;
        i_src_b   = '0;
        i_hold    = 1'b0;
        for (int r = 0; r < `ALU_NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        repeat (16) @(negedge i_clk);
        i_arst_n = 1'b1;
        repeat (4) @(negedge i_clk);
        quiet_window = 1'b0;
        run_directed();
        if (!aborted) run_same_cycle();
        if (!aborted) run_hold_overflow();
        if (!aborted) run_random(60);
        a_drop_count: assert (aborted || drop_cnt == 1)
            else begin
                mismatch_cnt++;
                $display("MISMATCH hold_overflow drops expected 1 actual %0d", drop_cnt);
            end
        $display("Done: %0d mismatches, %0d other errors, %0d results, %0d drops",
                 mismatch_cnt, fail_cnt, result_cnt, drop_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
